/* pit_pkg.sv */
// shared types and port map
// for the timer peripheral block

package pit_pkg;

    // I/O word address, indexed by byte address bit so that bit 1 selects the lane pair
    typedef logic [15:1] io_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0] byte_sel_t;
    typedef logic [15:0] count_t;
    typedef logic [7:0] irq_vec_t;

    // timer control word fields
    typedef logic [1:0] rw_t;
    typedef logic [2:0] pit_mode_t;
    typedef logic [1:0] pit_chan_t;

    typedef struct packed {
        io_addr_t  addr;
        bus_data_t wdata;
        byte_sel_t bytesel;
        logic      wr_en;
        logic      access;
    } bus_req_t;

    typedef struct packed {
        bus_data_t rdata;
        logic      ack;
    } bus_rsp_t;

    // byte ports 0x40 to 0x43 and 0x20 to 0x23 as word addresses
    localparam io_addr_t PIT_BASE = 15'h0020;
    localparam io_addr_t PIC_BASE = 15'h0010;

    localparam rw_t RW_LATCH = 2'b00;
    localparam rw_t RW_LSB   = 2'b01;
    localparam rw_t RW_MSB   = 2'b10;
    localparam rw_t RW_BOTH  = 2'b11;

    localparam pit_chan_t PIT_CHAN0 = 2'b00;

endpackage

/* bit_sync.sv */
// two-flop synchronizer

`timescale 1ns/1ps

module bit_sync (
    input  logic clk,
    input  logic reset,
    input  logic d,
    output logic q
);

    logic meta;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            meta <= 1'b0;
            q    <= 1'b0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

/* pit_timer.sv */
// interval timer, channel 0
// control, reload, latch and count logic

`timescale 1ns/1ps

module pit_timer
    import pit_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     pit_tick,
    input  logic     cs,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     timer_out
);

    logic      tick_q;
    logic      tick_rise;
    logic      access_data;
    logic      access_ctrl;
    logic [7:0] ctrl_byte;
    logic      ctrl_wr;
    logic      data_wr;
    logic      data_rd;
    logic      latch_cmd;
    logic [7:0] rd_byte;

    count_t    count;
    count_t    reload;
    count_t    latched_count;
    rw_t       rw;
    pit_mode_t mode;
    logic [1:0] latched;
    logic      low_next;
    logic      reload_done;

    // data sits on the low lane at offset 0, control on the high lane at offset 2
    assign access_data = cs & req.access & ~req.addr[1] & req.bytesel[0];
    assign access_ctrl = cs & req.access & req.addr[1] & req.bytesel[1];
    assign ctrl_byte   = req.wdata[15:8];

    assign ctrl_wr = access_ctrl & req.wr_en & (pit_chan_t'(ctrl_byte[7:6]) == PIT_CHAN0);
    assign data_wr = access_data & req.wr_en;
    assign data_rd = access_data & ~req.wr_en;

    // a latch command while bytes are still pending is ignored
    assign latch_cmd = ctrl_wr & (rw_t'(ctrl_byte[5:4]) == RW_LATCH) & ~|latched;

    assign tick_rise = pit_tick & ~tick_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= pit_tick;
        end
    end

    // control word, byte pointer and latch state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rw       <= RW_LATCH;
            mode     <= '0;
            low_next <= 1'b0;
            latched  <= 2'b00;
        end else if (ctrl_wr) begin
            if (rw_t'(ctrl_byte[5:4]) == RW_LATCH) begin
                if (latch_cmd) begin
                    latched <= 2'b11;
                end
            end else begin
                rw       <= ctrl_byte[5:4];
                mode     <= ctrl_byte[3:1];
                low_next <= ctrl_byte[4];
            end
        end else if (data_wr && rw == RW_BOTH) begin
            low_next <= ~low_next;
        end else if (data_rd && |latched) begin
            latched <= {1'b0, latched[1]};
        end
    end

    // latched bytes shift down as they are read out
    always_ff @(posedge clk) begin
        if (latch_cmd) begin
            latched_count <= count;
        end else if (data_rd && |latched) begin
            latched_count <= {8'h00, latched_count[15:8]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reload      <= '0;
            reload_done <= 1'b0;
        end else begin
            reload_done <= 1'b0;
            if (data_wr) begin
                if (low_next) begin
                    reload[7:0] <= req.wdata[7:0];
                end else begin
                    reload[15:8] <= req.wdata[7:0];
                    reload_done  <= 1'b1;
                end
            end
        end
    end

    // only the periodic modes count, and the output dips for the tick through 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= '0;
            timer_out <= 1'b0;
        end else if (reload_done) begin
            count <= reload - 16'd1;
        end else if (tick_rise && mode[1]) begin
            count     <= ((count == 16'd0) ? reload : count) - 16'd1;
            timer_out <= (count != 16'd1);
        end
    end

    always_comb begin
        if (|latched) begin
            rd_byte = latched_count[7:0];
        end else if (rw[0]) begin
            rd_byte = count[7:0];
        end else begin
            rd_byte = count[15:8];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.ack   <= cs & req.access;
            rsp.rdata <= data_rd ? {8'h00, rd_byte} : '0;
        end
    end

endmodule

/* irq_ctrl.sv */
// edge-triggered interrupt controller

`timescale 1ns/1ps

module irq_ctrl
    import pit_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cs,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    input  irq_vec_t irq_lines,
    output logic     irq
);

    logic     access_lo;
    logic     access_hi;
    irq_vec_t lines_q;
    irq_vec_t edges;
    irq_vec_t eoi_clear;
    irq_vec_t mask;
    irq_vec_t pending;

    // pending and end-of-interrupt on the low lane, mask on the high lane
    assign access_lo = cs & req.access & ~req.addr[1] & req.bytesel[0];
    assign access_hi = cs & req.access & req.addr[1] & req.bytesel[1];

    assign edges     = irq_lines & ~lines_q;
    assign eoi_clear = (access_lo & req.wr_en) ? req.wdata[7:0] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lines_q <= '0;
        end else begin
            lines_q <= irq_lines;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask <= '1;
        end else if (access_hi && req.wr_en) begin
            mask <= req.wdata[15:8];
        end
    end

    // a new edge wins over a clear of the same bit in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~eoi_clear) | (edges & ~mask);
        end
    end

    assign irq = |pending;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.ack <= cs & req.access;
            if (access_lo && !req.wr_en) begin
                rsp.rdata <= {8'h00, pending};
            end else if (access_hi && !req.wr_en) begin
                rsp.rdata <= {mask, 8'h00};
            end else begin
                rsp.rdata <= '0;
            end
        end
    end

endmodule

/* io_decode.sv */
// I/O port decoder and response merge

`timescale 1ns/1ps

module io_decode
    import pit_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t req,
    output logic     pit_cs,
    output logic     pic_cs,
    input  bus_rsp_t pit_rsp,
    input  bus_rsp_t pic_rsp,
    output bus_rsp_t rsp
);

    logic unmapped_ack;

    // each base covers a pair of words, so addr bit 1 is left to the peripheral
    assign pit_cs = (req.addr[15:2] == PIT_BASE[15:2]);
    assign pic_cs = (req.addr[15:2] == PIC_BASE[15:2]);

    // nobody else answers an unmapped port, so the decoder acks it itself
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= req.access & ~pit_cs & ~pic_cs;
        end
    end

    // peripherals drive zero rdata when idle, so a plain OR merges them
    always_comb begin
        rsp.rdata = pit_rsp.rdata | pic_rsp.rdata;
        rsp.ack   = pit_rsp.ack | pic_rsp.ack | unmapped_ack;
    end

endmodule

/* timer_subsystem.sv */
// timer subsystem top level

`timescale 1ns/1ps

module timer_subsystem
    import pit_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pit_clk,
    input  bus_req_t   req,
    output bus_rsp_t   rsp,
    input  logic [7:1] irq_in,
    output logic       irq
);

    logic     pit_cs;
    logic     pic_cs;
    logic     pit_tick;
    logic     timer_out;
    bus_rsp_t pit_rsp;
    bus_rsp_t pic_rsp;
    irq_vec_t irq_lines;

    // the timer owns request line 0
    assign irq_lines = {irq_in, timer_out};

    io_decode u_io_decode (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .pit_cs  (pit_cs),
        .pic_cs  (pic_cs),
        .pit_rsp (pit_rsp),
        .pic_rsp (pic_rsp),
        .rsp     (rsp)
    );

    bit_sync u_pit_sync (
        .clk   (clk),
        .reset (reset),
        .d     (pit_clk),
        .q     (pit_tick)
    );

    pit_timer u_pit_timer (
        .clk       (clk),
        .reset     (reset),
        .pit_tick  (pit_tick),
        .cs        (pit_cs),
        .req       (req),
        .rsp       (pit_rsp),
        .timer_out (timer_out)
    );

    irq_ctrl u_irq_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cs        (pic_cs),
        .req       (req),
        .rsp       (pic_rsp),
        .irq_lines (irq_lines),
        .irq       (irq)
    );

endmodule

/* tb_checker.sv */
// bus and interrupt checker

`timescale 1ns/1ps

module tb_checker
    import pit_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  bus_req_t        req,
    input  bus_rsp_t        rsp,
    input  logic            irq,
    input  logic            rd_check,
    input  bus_data_t       rd_exp,
    input  logic            irq_check,
    input  logic            irq_exp,
    input  logic            test_end,
    input  logic [8*24-1:0] test_name,
    input  logic            run_done,
    output int              errors
);

    logic      acc_q;
    logic      rd_q;
    bus_data_t exp_q;
    io_addr_t  addr_q;
    int        test_errors;
    int        tests_run;
    int        tests_failed;

    task automatic note_error();
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    // the DUT answers every access on the following cycle, so the request is kept one cycle
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q        <= 1'b0;
            rd_q         <= 1'b0;
            exp_q        <= '0;
            addr_q       <= '0;
            errors       = 0;
            test_errors  = 0;
            tests_run    = 0;
            tests_failed = 0;
        end else begin
            acc_q  <= req.access;
            rd_q   <= req.access & ~req.wr_en & rd_check;
            exp_q  <= rd_exp;
            addr_q <= req.addr;

            if (acc_q && rsp.ack !== 1'b1) begin
                $display("no ack on the cycle after the access to port %h", {addr_q, 1'b0});
                note_error();
            end
            if (!acc_q && rsp.ack !== 1'b0) begin
                $display("ack seen on a cycle that follows no access");
                note_error();
            end
            // read data must stay at zero outside an ack
            if (rsp.ack !== 1'b1 && rsp.rdata !== '0) begin
                $display("CHECK FAILED rsp.rdata with ack low: got %h expected 0000", rsp.rdata);
                note_error();
            end
            if (rd_q && rsp.ack === 1'b1 && rsp.rdata !== exp_q) begin
                $display("CHECK FAILED rsp.rdata at port %h: got %h expected %h",
                         {addr_q, 1'b0}, rsp.rdata, exp_q);
                note_error();
            end
            if (irq_check && irq !== irq_exp) begin
                $display("CHECK FAILED irq: got %h expected %h", irq, irq_exp);
                note_error();
            end

            if (test_end) begin
                tests_run = tests_run + 1;
                if (test_errors == 0) begin
                    $display("test %0s: ok", test_name);
                end else begin
                    $display("test %0s: FAILED with %0d errors", test_name, test_errors);
                    tests_failed = tests_failed + 1;
                end
                test_errors = 0;
            end
            if (run_done) begin
                $display("tests run: %0d, tests failed: %0d, errors: %0d",
                         tests_run, tests_failed, errors);
            end
        end
    end

endmodule

/* tb_timer_subsystem.sv */
// testbench top for the timer subsystem

`timescale 1ns/1ps

module tb_timer_subsystem
    import pit_pkg::*;
();

    logic            clk;
    logic            reset;
    logic            pit_clk;
    bus_req_t        req;
    bus_rsp_t        rsp;
    logic [7:1]      irq_in;
    logic            irq;
    logic            rd_check;
    bus_data_t       rd_exp;
    logic            irq_check;
    logic            irq_exp;
    logic            test_end;
    logic [8*24-1:0] test_name;
    logic            run_done;
    int              errors;
    int              tb_errors;
    int              fd;
    int              cycles = 0;
    int              cycle_limit = 0;

    timer_subsystem u_dut (
        .clk     (clk),
        .reset   (reset),
        .pit_clk (pit_clk),
        .req     (req),
        .rsp     (rsp),
        .irq_in  (irq_in),
        .irq     (irq)
    );

    tb_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .rsp       (rsp),
        .irq       (irq),
        .rd_check  (rd_check),
        .rd_exp    (rd_exp),
        .irq_check (irq_check),
        .irq_exp   (irq_exp),
        .test_end  (test_end),
        .test_name (test_name),
        .run_done  (run_done),
        .errors    (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles before the data file was finished", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic read_record(output int got, output logic [8*16-1:0] op,
                               output logic [15:0] f0, output logic [15:0] f1,
                               output logic [15:0] f2, output logic [8*24-1:0] name);
        logic [8*128-1:0] rest;
        int               n;
        op   = '0;
        f0   = '0;
        f1   = '0;
        f2   = '0;
        name = '0;
        n    = $fscanf(fd, "%s", op);
        // a comment line starts with a lone # and is dropped whole
        while (n == 1 && op == "#") begin
            n = $fgets(rest, fd);
            n = $fscanf(fd, "%s", op);
        end
        got = int'(n == 1);
        if (got == 1 && (op == "write" || op == "read")) begin
            n = $fscanf(fd, "%h %h %h", f0, f1, f2);
        end else if (got == 1 && op == "end_test") begin
            n = $fscanf(fd, "%s", name);
        end else if (got == 1) begin
            n = $fscanf(fd, "%h", f0);
        end
    endtask

    function automatic int record_cost(input logic [8*16-1:0] op, input logic [15:0] f0);
        if (op == "tick") begin
            return 16 * int'(f0) + 2;
        end else if (op == "expect_irq") begin
            return 6;
        end
        return 4;
    endfunction

    task automatic cost_records(output int limit);
        int               got;
        logic [8*16-1:0]  op;
        logic [15:0]      f0;
        logic [15:0]      f1;
        logic [15:0]      f2;
        logic [8*24-1:0]  name;
        limit = 10;
        read_record(got, op, f0, f1, f2, name);
        while (got == 1) begin
            limit = limit + record_cost(op, f0);
            read_record(got, op, f0, f1, f2, name);
        end
        limit = 2 * limit;
        $fclose(fd);
        fd = $fopen("timer_input.txt", "r");
    endtask

    task automatic bus_cycle(input logic [15:0] port, input logic [15:0] bytesel,
                             input logic [15:0] data, input logic wr);
        int waited;
        req.addr    = port[15:1];
        req.bytesel = bytesel[1:0];
        req.wr_en   = wr;
        req.wdata   = wr ? data : 16'h0000;
        req.access  = 1'b1;
        rd_check    = ~wr;
        rd_exp      = data;
        @(posedge clk);
        #1;
        req.access = 1'b0;
        rd_check   = 1'b0;
        waited     = 0;
        while (!rsp.ack && waited < 8) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
        @(posedge clk);
        #1;
    endtask

    // each pulse is long enough for the synchronizer and the count update
    task automatic pulse_pit_clk(input int pulses);
        repeat (pulses) begin
            pit_clk = 1'b1;
            repeat (8) @(posedge clk);
            #1;
            pit_clk = 1'b0;
            repeat (8) @(posedge clk);
            #1;
        end
    endtask

    task automatic replay_records();
        int               got;
        logic [8*16-1:0]  op;
        logic [15:0]      f0;
        logic [15:0]      f1;
        logic [15:0]      f2;
        logic [8*24-1:0]  name;
        read_record(got, op, f0, f1, f2, name);
        while (got == 1) begin
            if (op == "write" || op == "read") begin
                bus_cycle(f0, f1, f2, op == "write");
            end else if (op == "tick") begin
                pulse_pit_clk(int'(f0));
            end else if (op == "irq") begin
                irq_in = f0[7:1];
                @(posedge clk);
                #1;
            end else if (op == "expect_irq") begin
                // an edge reaches pending two cycles after it arrives
                repeat (4) @(posedge clk);
                #1;
                irq_exp   = f0[0];
                irq_check = 1'b1;
                @(posedge clk);
                #1;
                irq_check = 1'b0;
            end else if (op == "end_test") begin
                test_name = name;
                test_end  = 1'b1;
                @(posedge clk);
                #1;
                test_end = 1'b0;
            end else begin
                $display("unknown record %0s in timer_input.txt", op);
                tb_errors = tb_errors + 1;
            end
            read_record(got, op, f0, f1, f2, name);
        end
    endtask

    initial begin
        reset     = 1'b1;
        pit_clk   = 1'b0;
        req       = '0;
        irq_in    = '0;
        rd_check  = 1'b0;
        rd_exp    = '0;
        irq_check = 1'b0;
        irq_exp   = 1'b0;
        test_end  = 1'b0;
        test_name = '0;
        run_done  = 1'b0;
        tb_errors = 0;
        fd        = $fopen("timer_input.txt", "r");
        if (fd == 0) begin
            $display("could not open timer_input.txt");
            $display("Verification failed");
            $finish;
        end else begin
            cost_records(cycle_limit);
            repeat (10) @(posedge clk);
            #1;
            reset = 1'b0;
            replay_records();
            $fclose(fd);
            run_done = 1'b1;
            @(posedge clk);
            #1;
            run_done = 1'b0;
            repeat (2) @(posedge clk);
            #1;
            if (errors == 0 && tb_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

/* timer_input.txt */
# columns: write <port> <bytesel> <data>, read <port> <bytesel> <expected data>
# tick <pulses>, irq <lines 7..0>, expect_irq <level>, end_test <name>; numbers are hex
write 80 1 1234
read 80 3 0000
read 42 2 0000
read 22 2 ff00
end_test bus_response
write 42 2 3400
write 40 1 0034
write 40 1 0002
tick 5
write 42 2 0000
read 40 1 002e
read 40 1 0002
write 42 2 3400
write 40 1 0003
write 40 1 0000
tick 4
write 42 2 0000
read 40 1 0001
read 40 1 0000
end_test reload_and_count
write 42 2 3400
write 40 1 0000
write 40 1 0001
tick 2
write 42 2 0000
tick 3
read 40 1 00fd
read 40 1 0000
write 42 2 0000
read 40 1 00fa
read 40 1 0000
end_test latch_hold
write 42 2 3000
write 40 1 0034
write 40 1 0012
tick 3
write 42 2 1000
read 40 1 0033
write 42 2 2000
read 40 1 0012
end_test counting_gate
write 22 2 fe00
write 42 2 3400
write 40 1 0003
write 40 1 0000
tick 2
expect_irq 0
tick 1
expect_irq 1
read 20 1 0001
write 20 1 0001
expect_irq 0
write 22 2 ff00
tick 3
expect_irq 0
read 20 1 0000
end_test timer_interrupt
write 22 2 df00
read 22 2 df00
irq 20
expect_irq 1
read 20 1 0020
write 20 1 0020
expect_irq 0
read 20 1 0000
end_test external_line

/* sim.f */
pit_pkg.sv
bit_sync.sv
pit_timer.sv
irq_ctrl.sv
io_decode.sv
timer_subsystem.sv
tb_checker.sv
tb_timer_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the timer subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module tb_timer_subsystem -o tb_timer_subsystem
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_timer_subsystem > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1
